// File: hw/alu_cfg.svh
/*
 * ALU configuration
 * Data and tag widths shared by the integer execution unit
 */

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// ##################################################
// Data path
// ##################################################
// The shifter's bit reversal and its 16/4/1 stages are built for 32 bits
`define ALU_XLEN 32

// ##################################################
// Instruction tag
// ##################################################
`define ALU_ID_W 3 // Wide enough to name every operation in flight

`endif

// File: hw/alu_pkg.sv
/*
 * ALU types
 * Opcodes, datapath function selects and the structs passed between stages
 */

`include "alu_cfg.svh"

package alu_pkg;

    // Operations accepted at issue
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_SLT  = 4'h2,
        OP_SLTU = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_SLL  = 4'h7,
        OP_SRL  = 4'h8,
        OP_SRA  = 4'h9
    } alu_op_t;

    // Adder and logic unit result select where SUB is FN_ADD with subtract set
    typedef enum logic [2:0] {
        FN_ADD  = 3'd0,
        FN_SLT  = 3'd1,
        FN_SLTU = 3'd2,
        FN_AND  = 3'd3,
        FN_OR   = 3'd4,
        FN_XOR  = 3'd5
    } logic_fn_t;

    typedef struct packed {
        alu_op_t                    op;
        logic [`ALU_XLEN-1:0]       rs1;
        logic [`ALU_XLEN-1:0]       rs2;
        logic [`ALU_ID_W-1:0]       id;
    } alu_issue_t;

    // Decoded controls for both datapaths, registered in the issue stage
    typedef struct packed {
        logic                       use_shift;    // Result comes from the shifter
        logic                       lshift;       // Shift toward the MSB
        logic                       arith;        // Fill bit for vacated positions
        logic [4:0]                 shift_amount;
        logic                       subtract;     // Invert b and carry in a one
        logic_fn_t                  fn;
        logic [`ALU_ID_W-1:0]       id;
    } alu_ctrl_t;

    typedef struct packed {
        logic                       valid;
        logic [`ALU_ID_W-1:0]       id;
        logic [`ALU_XLEN-1:0]       result;
    } alu_wb_t;

endpackage

// File: hw/alu_issue_stage.sv
/*
 * ALU issue stage
 * Registers an issued operation and decodes its opcode into controls
 * for the barrel shifter and the adder and logic unit
 */

`timescale 1ns/1ns

`include "alu_cfg.svh"

module alu_issue_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  alu_pkg::alu_issue_t     issue,
    output logic                    stage_valid,
    output alu_pkg::alu_ctrl_t      ctrl,
    output logic [`ALU_XLEN-1:0]    op_a,
    output logic [`ALU_XLEN-1:0]    op_b
);

    alu_pkg::alu_ctrl_t dec_ctrl; // Controls decoded from the incoming issue

    // ##################################################
    // Opcode decode
    // ##################################################
    always_comb begin
        // Plain add with no shift is the starting point for every opcode
        dec_ctrl.use_shift    = 1'b0;
        dec_ctrl.lshift       = 1'b0;
        dec_ctrl.arith        = 1'b0;
        dec_ctrl.shift_amount = issue.rs2[4:0]; // Only the low five bits of rs2 count
        dec_ctrl.subtract     = 1'b0;
        dec_ctrl.fn           = alu_pkg::FN_ADD;
        dec_ctrl.id           = issue.id;

        case (issue.op)
            alu_pkg::OP_ADD:  dec_ctrl.fn = alu_pkg::FN_ADD;
            alu_pkg::OP_SUB:  dec_ctrl.subtract = 1'b1;
            alu_pkg::OP_SLT: begin
                dec_ctrl.subtract = 1'b1; // Compares are taken from a - b
                dec_ctrl.fn       = alu_pkg::FN_SLT;
            end
            alu_pkg::OP_SLTU: begin
                dec_ctrl.subtract = 1'b1;
                dec_ctrl.fn       = alu_pkg::FN_SLTU;
            end
            alu_pkg::OP_AND:  dec_ctrl.fn = alu_pkg::FN_AND;
            alu_pkg::OP_OR:   dec_ctrl.fn = alu_pkg::FN_OR;
            alu_pkg::OP_XOR:  dec_ctrl.fn = alu_pkg::FN_XOR;
            alu_pkg::OP_SLL: begin
                dec_ctrl.use_shift = 1'b1;
                dec_ctrl.lshift    = 1'b1; // Shifter flips the word around its right shift
            end
            alu_pkg::OP_SRL:  dec_ctrl.use_shift = 1'b1;
            alu_pkg::OP_SRA: begin
                dec_ctrl.use_shift = 1'b1;
                dec_ctrl.arith     = issue.rs1[`ALU_XLEN-1]; // Sign fills from the top
            end
            default: dec_ctrl.fn = alu_pkg::FN_ADD; // Unused encodings act as ADD
        endcase
    end

    // ##################################################
    // Stage registers
    // ##################################################
    always_ff @(posedge clk) begin
        if (rst)
            stage_valid <= 1'b0;
        else
            stage_valid <= issue_valid; // One cycle behind the issue strobe
    end

    // Operands and controls load every cycle and are qualified by stage_valid
    always_ff @(posedge clk) begin
        ctrl <= dec_ctrl;
        op_a <= issue.rs1;
        op_b <= issue.rs2;
    end

endmodule

// File: hw/barrel_shifter.sv
/*
 * Barrel shifter
 * One logarithmic right shifter serves SLL, SRL and SRA. Left shifts
 * reverse the word on the way in and again on the way out
 */

`timescale 1ns/1ns

`include "alu_cfg.svh"

module barrel_shifter (
    input  logic [`ALU_XLEN-1:0]    shifter_input,
    input  logic [4:0]              shift_amount,
    input  logic                    arith,
    input  logic                    lshift,
    output logic [`ALU_XLEN-1:0]    shifted_result
);

    logic [`ALU_XLEN-1:0]  flipped_input;   // Input with bit order reversed
    logic [`ALU_XLEN-1:0]  shifter_in;      // Word entering the right shifter
    logic [`ALU_XLEN-1:0]  shiftx16;        // After the shift by 0 or 16
    logic [`ALU_XLEN+11:0] shiftx16_padded; // Room for up to 12 fill bits
    logic [`ALU_XLEN-1:0]  shiftx4;         // After the shift by 0, 4, 8 or 12
    logic [`ALU_XLEN+2:0]  shiftx4_padded;  // Room for up to 3 fill bits
    logic [`ALU_XLEN-1:0]  shiftx1;         // Fully right shifted word
    logic [`ALU_XLEN-1:0]  flipped_output;  // Right shift result reversed back

    // ##################################################
    // Input reversal
    // ##################################################
    always_comb begin
        for (int i = 0; i < `ALU_XLEN; i++) begin
            flipped_input[i] = shifter_input[`ALU_XLEN-1-i];
        end
    end

    assign shifter_in = lshift ? flipped_input : shifter_input;

    // ##################################################
    // Right shift stages
    // ##################################################
    // The upper half drops into the lower half when bit 4 is set
    assign shiftx16 = shift_amount[4] ? {{16{arith}}, shifter_in[`ALU_XLEN-1:16]}
                                      : shifter_in;

    assign shiftx16_padded = {{12{arith}}, shiftx16};

    always_comb begin
        case (shift_amount[3:2])
            2'd0:    shiftx4 = shiftx16_padded[`ALU_XLEN-1:0];
            2'd1:    shiftx4 = shiftx16_padded[`ALU_XLEN+3:4];
            2'd2:    shiftx4 = shiftx16_padded[`ALU_XLEN+7:8];
            default: shiftx4 = shiftx16_padded[`ALU_XLEN+11:12];
        endcase
    end

    assign shiftx4_padded = {{3{arith}}, shiftx4};

    always_comb begin
        case (shift_amount[1:0])
            2'd0:    shiftx1 = shiftx4_padded[`ALU_XLEN-1:0];
            2'd1:    shiftx1 = shiftx4_padded[`ALU_XLEN:1];
            2'd2:    shiftx1 = shiftx4_padded[`ALU_XLEN+1:2];
            default: shiftx1 = shiftx4_padded[`ALU_XLEN+2:3];
        endcase
    end

    // ##################################################
    // Output reversal
    // ##################################################
    always_comb begin
        for (int i = 0; i < `ALU_XLEN; i++) begin
            flipped_output[i] = shiftx1[`ALU_XLEN-1-i];
        end
    end

    // A reversed right shift with zero fill is the left shift
    assign shifted_result = lshift ? flipped_output : shiftx1;

endmodule

// File: hw/adder_logic_unit.sv
/*
 * Adder and logic unit
 * Add, subtract, signed and unsigned set-less-than, AND, OR and XOR
 * from one shared adder with a carry-in
 */

`timescale 1ns/1ns

`include "alu_cfg.svh"

module adder_logic_unit (
    input  logic [`ALU_XLEN-1:0]    a,
    input  logic [`ALU_XLEN-1:0]    b,
    input  logic                    subtract,
    input  alu_pkg::logic_fn_t      fn,
    output logic [`ALU_XLEN-1:0]    alu_result
);

    logic [`ALU_XLEN-1:0] b_operand;    // b, inverted for subtraction
    logic [`ALU_XLEN:0]   sum_ext;      // Sum with the carry out on top
    logic [`ALU_XLEN-1:0] sum;
    logic                 lt_signed;
    logic                 lt_unsigned;

    // ##################################################
    // Shared adder
    // ##################################################
    assign b_operand = b ^ {`ALU_XLEN{subtract}};

    // a + ~b + 1 gives a - b and the extra bit keeps the carry
    assign sum_ext = {1'b0, a} + {1'b0, b_operand} + {{`ALU_XLEN{1'b0}}, subtract};
    assign sum     = sum_ext[`ALU_XLEN-1:0];

    // ##################################################
    // Compares
    // ##################################################
    // No carry out of a - b means a borrow, so a is below b unsigned
    assign lt_unsigned = ~sum_ext[`ALU_XLEN];

    always_comb begin
        if (a[`ALU_XLEN-1] != b[`ALU_XLEN-1])
            lt_signed = a[`ALU_XLEN-1];     // Differing signs decide it alone
        else
            lt_signed = sum[`ALU_XLEN-1];   // Same sign means the difference cannot overflow
    end

    // ##################################################
    // Result select
    // ##################################################
    always_comb begin
        case (fn)
            alu_pkg::FN_ADD:  alu_result = sum;
            alu_pkg::FN_SLT:  alu_result = {{(`ALU_XLEN-1){1'b0}}, lt_signed};
            alu_pkg::FN_SLTU: alu_result = {{(`ALU_XLEN-1){1'b0}}, lt_unsigned};
            alu_pkg::FN_AND:  alu_result = a & b;
            alu_pkg::FN_OR:   alu_result = a | b;
            alu_pkg::FN_XOR:  alu_result = a ^ b;
            default:          alu_result = sum;  // Encodings 6 and 7 are never decoded
        endcase
    end

endmodule

// File: hw/alu_result_stage.sv
/*
 * ALU result stage
 * Picks the shifter or the adder result and registers the writeback
 */

`timescale 1ns/1ns

`include "alu_cfg.svh"

module alu_result_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stage_valid,
    input  logic                    use_shift,
    input  logic [`ALU_ID_W-1:0]    id,
    input  logic [`ALU_XLEN-1:0]    shifted_result,
    input  logic [`ALU_XLEN-1:0]    alu_result,
    output alu_pkg::alu_wb_t        wb
);

    logic [`ALU_XLEN-1:0] selected_result;  // Result chosen for this cycle
    logic                 wb_valid;
    logic [`ALU_ID_W-1:0] wb_id;
    logic [`ALU_XLEN-1:0] wb_result;

    // ##################################################
    // Result mux
    // ##################################################
    // Both datapaths always compute and only one answer is kept
    assign selected_result = use_shift ? shifted_result : alu_result;

    // ##################################################
    // Writeback register
    // ##################################################
    always_ff @(posedge clk) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= stage_valid; // Lands two cycles after the issue strobe
    end

    always_ff @(posedge clk) begin
        wb_id     <= id;
        wb_result <= selected_result;
    end

    // Tag travels with its result so writebacks come out in issue order
    always_comb begin
        wb.valid  = wb_valid;
        wb.id     = wb_id;
        wb.result = wb_result;
    end

endmodule

// File: hw/alu_unit.sv
/*
 * ALU execution unit
 * Issue decode, shifter and adder side by side, then a registered writeback
 */

`timescale 1ns/1ns

`include "alu_cfg.svh"

module alu_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  alu_pkg::alu_issue_t     issue,
    output alu_pkg::alu_wb_t        wb
);

    logic                   stage_valid;
    alu_pkg::alu_ctrl_t     ctrl;
    logic [`ALU_XLEN-1:0]   op_a;
    logic [`ALU_XLEN-1:0]   op_b;
    logic [`ALU_XLEN-1:0]   shifted_result;
    logic [`ALU_XLEN-1:0]   alu_result;

    alu_issue_stage alu_issue_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .stage_valid    (stage_valid),
        .ctrl           (ctrl),
        .op_a           (op_a),
        .op_b           (op_b)
    );

    barrel_shifter barrel_shifter_inst (
        .shifter_input  (op_a),
        .shift_amount   (ctrl.shift_amount),
        .arith          (ctrl.arith),
        .lshift         (ctrl.lshift),
        .shifted_result (shifted_result)
    );

    adder_logic_unit adder_logic_unit_inst (
        .a              (op_a),
        .b              (op_b),
        .subtract       (ctrl.subtract),
        .fn             (ctrl.fn),
        .alu_result     (alu_result)
    );

    alu_result_stage alu_result_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .stage_valid    (stage_valid),
        .use_shift      (ctrl.use_shift),
        .id             (ctrl.id),
        .shifted_result (shifted_result),
        .alu_result     (alu_result),
        .wb             (wb)
    );

endmodule

// File: verification/alu_unit_tb.sv
/*
 * ALU execution unit testbench
 * Directed and seeded random issues checked against an operator model,
 * with tag order and the two cycle writeback latency tracked per result
 */

`timescale 1ns/1ns

`include "alu_cfg.svh"

module alu_unit_tb;

    // One expected writeback that is pushed at issue and popped when wb.valid is seen
    typedef struct packed {
        logic [`ALU_ID_W-1:0] id;
        logic [`ALU_XLEN-1:0] result;
        logic [31:0]          issue_cycle;  // Cycle count at the issue strobe
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 issue_valid;
    alu_pkg::alu_issue_t  issue;
    alu_pkg::alu_wb_t     wb;

    expect_t              expect_q[$];    // Results in flight, oldest first
    integer               seed;
    int                   errors;
    logic [31:0]          cycle_count;
    logic [`ALU_ID_W-1:0] next_id;        // Tag given to the next issue
    string                current_test;
    logic                 checking;       // Monitor is armed once reset is released

    alu_unit alu_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    always @(posedge clk) begin
        if (rst)
            cycle_count <= 32'd0;
        else
            cycle_count <= cycle_count + 32'd1;
    end

    // ##################################################
    // Helpers
    // ##################################################
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic int random_below(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // Corner values turn up often enough to hit overflow and equal operands
    function automatic logic [31:0] random_operand();
        logic [31:0] corners [5];
        corners = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        if (random_below(4) == 0)
            return corners[random_below(5)];
        return random_word();
    endfunction

    // Reference results straight from the RV32I operation definitions
    function automatic logic [`ALU_XLEN-1:0] expected_result(input alu_pkg::alu_op_t op,
            input logic [`ALU_XLEN-1:0] rs1, input logic [`ALU_XLEN-1:0] rs2);
        logic [4:0]           shamt;
        logic [`ALU_XLEN-1:0] result;
        shamt = rs2[4:0]; // Upper bits of rs2 never matter for shifts
        case (op)
            alu_pkg::OP_ADD:  result = rs1 + rs2;
            alu_pkg::OP_SUB:  result = rs1 - rs2;
            alu_pkg::OP_SLT:  result = ($signed(rs1) < $signed(rs2)) ? 32'd1 : 32'd0;
            alu_pkg::OP_SLTU: result = (rs1 < rs2) ? 32'd1 : 32'd0;
            alu_pkg::OP_AND:  result = rs1 & rs2;
            alu_pkg::OP_OR:   result = rs1 | rs2;
            alu_pkg::OP_XOR:  result = rs1 ^ rs2;
            alu_pkg::OP_SLL:  result = rs1 << shamt;
            alu_pkg::OP_SRL:  result = rs1 >> shamt;
            alu_pkg::OP_SRA:  result = $signed(rs1) >>> shamt;
            default:          result = 'x;
        endcase
        return result;
    endfunction

    // Drives one issue on the next falling edge and leaves the strobe high
    task automatic issue_op(input alu_pkg::alu_op_t op, input logic [`ALU_XLEN-1:0] rs1,
                            input logic [`ALU_XLEN-1:0] rs2);
        expect_t entry;
        @(negedge clk);
        issue_valid = 1'b1;
        issue.op    = op;
        issue.rs1   = rs1;
        issue.rs2   = rs2;
        issue.id    = next_id;
        entry.id          = next_id;
        entry.result      = expected_result(op, rs1, rs2);
        entry.issue_cycle = cycle_count;
        expect_q.push_back(entry);
        next_id = next_id + 1'b1; // Tag wraps since at most two are ever in flight
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clk);
            issue_valid = 1'b0;
            issue.rs1   = random_word(); // Junk operands must be ignored when idle
            issue.rs2   = random_word();
        end
    endtask

    task automatic drain_queue(input int max_cycles);
        int waited;
        waited = 0;
        idle_cycles(1);
        while (expect_q.size() != 0 && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("Timed out in %s with %0d results never written back",
                     current_test, expect_q.size());
        end
    endtask

    // ##################################################
    // Writeback monitor
    // ##################################################
    always @(posedge clk) begin : wb_monitor
        expect_t entry;
        if (checking) begin
            if (wb.valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("Writeback valid with nothing in flight during %s", current_test);
                end else begin
                    entry = expect_q.pop_front();
                    check_value({current_test, " id"}, entry.id, wb.id);
                    check_value({current_test, " result"}, entry.result, wb.result);
                    check_value({current_test, " latency"}, 32'd2,
                                cycle_count - entry.issue_cycle);
                end
            end else if (wb.valid !== 1'b0) begin
                errors++;
                $display("Writeback valid is unknown during %s", current_test);
            end
        end
    end

    // Hard limit on the whole run
    initial begin
        #200000;
        $display("Simulation ran past its time limit");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ##################################################
    // Stimulus
    // ##################################################
    initial begin
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue        = '0;
        seed         = 88;
        errors       = 0;
        next_id      = '0;
        checking     = 1'b0;
        current_test = "reset";

        repeat (5) begin
            @(negedge clk);
            check_value("reset valid", 32'd0, wb.valid);
        end
        rst      = 1'b0;
        checking = 1'b1;

        current_test = "idle after reset";
        idle_cycles(10);

        current_test = "directed arith";
        issue_op(alu_pkg::OP_ADD,  32'h7fff_ffff, 32'h0000_0001); // Signed overflow
        issue_op(alu_pkg::OP_ADD,  32'hffff_ffff, 32'h0000_0001); // Carry out dropped
        issue_op(alu_pkg::OP_SUB,  32'h8000_0000, 32'h0000_0001);
        issue_op(alu_pkg::OP_SUB,  32'h1234_5678, 32'h1234_5678);
        issue_op(alu_pkg::OP_SLT,  32'h1234_5678, 32'h1234_5678);
        issue_op(alu_pkg::OP_SLTU, 32'hdead_beef, 32'hdead_beef);
        issue_op(alu_pkg::OP_SLT,  32'hffff_ffff, 32'h0000_0001); // Signed and unsigned disagree
        issue_op(alu_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0001);
        issue_op(alu_pkg::OP_SLT,  32'h8000_0000, 32'h7fff_ffff);
        issue_op(alu_pkg::OP_SLTU, 32'h0000_0001, 32'hffff_ffff);
        issue_op(alu_pkg::OP_AND,  32'hf0f0_a5a5, 32'hff00_0ff0);
        issue_op(alu_pkg::OP_OR,   32'hf0f0_a5a5, 32'hff00_0ff0);
        issue_op(alu_pkg::OP_XOR,  32'hf0f0_a5a5, 32'hff00_0ff0);
        drain_queue(20);

        current_test = "directed shift";
        for (int k = 0; k < 5; k++) begin
            logic [31:0] amounts [5];
            amounts = '{32'd0, 32'd1, 32'd15, 32'd16, 32'd31};
            issue_op(alu_pkg::OP_SLL, 32'h8765_4321, amounts[k]);
            issue_op(alu_pkg::OP_SRL, 32'h8765_4321, amounts[k]);
            issue_op(alu_pkg::OP_SRA, 32'h8765_4321, amounts[k]); // Negative value
            issue_op(alu_pkg::OP_SRA, 32'h4765_4321, amounts[k]);
        end
        issue_op(alu_pkg::OP_SLL, 32'h0000_00ff, 32'hffff_ffe3); // Low five bits give 3
        issue_op(alu_pkg::OP_SRA, 32'h8000_0000, 32'h0000_0020); // 32 acts as 0
        issue_op(alu_pkg::OP_SRL, 32'hffff_ffff, 32'h7fff_ffe4);
        drain_queue(20);

        current_test = "random arith";
        repeat (200) begin
            issue_op(alu_pkg::alu_op_t'(4'(random_below(7))), random_operand(),
                     random_operand());
        end
        drain_queue(20);

        current_test = "random shift";
        repeat (200) begin
            issue_op(alu_pkg::alu_op_t'(4'(7 + random_below(3))), random_operand(),
                     random_word());
        end
        drain_queue(20);

        // Back-to-back issues broken up by short idle gaps
        current_test = "random mixed";
        repeat (300) begin
            issue_op(alu_pkg::alu_op_t'(4'(random_below(10))), random_operand(),
                     random_operand());
            if (random_below(4) == 0)
                idle_cycles(1 + random_below(3));
        end
        drain_queue(20);

        current_test = "final idle";
        idle_cycles(8); // Any late or duplicated writeback shows up here
        if (expect_q.size() != 0) begin
            errors++;
            $display("%0d expected results were left in the queue", expect_q.size());
        end

        $display("Test run finished with %0d errors", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_issue_stage.sv
hw/barrel_shifter.sv
hw/adder_logic_unit.sv
hw/alu_result_stage.sv
hw/alu_unit.sv
verification/alu_unit_tb.sv

// File: Bender.yml
package:
  name: alu_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/alu_pkg.sv
      - hw/alu_issue_stage.sv
      - hw/barrel_shifter.sv
      - hw/adder_logic_unit.sv
      - hw/alu_result_stage.sv
      - hw/alu_unit.sv

  - target: test
    include_dirs:
      - hw
    files:
      - verification/alu_unit_tb.sv
